// File: Bender.yml
package:
  name: sinc3_adc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sinc3_pkg.sv
      - sd_modulator_if.sv
      - sinc3_integrator.sv
      - sinc3_decimator.sv
      - sinc3_adc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sinc3_adc_assert.sv
      - sinc3_adc_tb.sv

// File: sd_modulator_if.sv
//------------------------------
// Modulator clock divider, bit synchronizer and bit strobe
//------------------------------
`include "sinc3_macros.svh"

module sd_modulator_if
(
    input  logic word_clk,
    input  logic reset_i,
    input  logic mdata_i,
    output logic mclkout_o,
    output logic bit_o,
    output logic bit_stb_o
);

    localparam int DIV  = `SINC_MCLK_DIV;
    localparam int PH_W = $clog2(DIV);

    // Position inside one modulator bit period
    logic [PH_W-1:0] phase_q;
    logic            ph_last;
    logic            ph_mid;

    // Two-flop synchronizer for the modulator data
    logic            sync1_q;
    logic            sync2_q;

    //------------------------------
    // Phase decode
    //------------------------------

    // Last cycle of the period, mclkout rises at its closing edge
    assign ph_last = (phase_q == PH_W'(DIV - 1));

    // End of the high half
    assign ph_mid = (phase_q == PH_W'(DIV / 2 - 1));

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            phase_q <= '0;
        end
        else if (ph_last)
        begin
            phase_q <= '0;
        end
        else
        begin
            phase_q <= phase_q + PH_W'(1);
        end
    end

    //------------------------------
    // Modulator clock
    //------------------------------

    // High for DIV/2 cycles, low for the rest
    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            mclkout_o <= 1'b0;
        end
        else if (ph_last)
        begin
            mclkout_o <= 1'b1;
        end
        else if (ph_mid)
        begin
            mclkout_o <= 1'b0;
        end
    end

    //------------------------------
    // Data capture
    //------------------------------

    // Bit launched at a rising mclkout edge settles through both flops
    // well before the next rising edge, where it is taken
    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            sync1_q   <= 1'b0;
            sync2_q   <= 1'b0;
            bit_o     <= 1'b0;
            bit_stb_o <= 1'b0;
        end
        else
        begin
            sync1_q   <= mdata_i;
            sync2_q   <= sync1_q;
            // One strobe per modulator bit
            bit_stb_o <= ph_last;
            if (ph_last)
            begin
                bit_o <= sync2_q;
            end
        end
    end

endmodule

// File: sinc3_adc_assert.sv
//------------------------------
// Concurrent checks on the sinc3 top, bound to the top level
//------------------------------
`include "sinc3_macros.svh"

module sinc3_adc_assert
(
    input logic                  word_clk,
    input logic                  reset_i,
    input logic                  mclk_i,
    input logic [15:0]           data_i,
    input logic                  data_rdy_i,
    input sinc3_pkg::dec_state_e dec_state_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import sinc3_pkg::*;

    localparam int HALF = `SINC_MCLK_DIV / 2;

    // Word strobe lasts a single cycle
    rdy_single: assert property (@(posedge word_clk) disable iff (reset_i)
        data_rdy_i |=> !data_rdy_i)
        else $error("data_rdy_o held longer than one cycle");

    // Warm-up words stay hidden
    rdy_in_run: assert property (@(posedge word_clk) disable iff (reset_i)
        data_rdy_i |-> (dec_state_i == ST_RUN))
        else $error("data_rdy_o pulsed during flush");

    // Modulator clock high half then low half
    mclk_period: assert property (@(posedge word_clk) disable iff (reset_i)
        $rose(mclk_i) |-> mclk_i [*HALF] ##1 !mclk_i [*HALF] ##1 mclk_i)
        else $error("mclkout_o period wrong");

    // Second reset cycle onward all outputs idle
    reset_quiet: assert property (@(posedge word_clk)
        reset_i ##1 reset_i |-> (!mclk_i && !data_rdy_i && (data_i == 16'h0000)))
        else $error("outputs active during reset");

endmodule

bind sinc3_adc_top sinc3_adc_assert u_assert
(
    .word_clk    (word_clk),
    .reset_i     (reset_i),
    .mclk_i      (mclkout_o),
    .data_i      (data_o),
    .data_rdy_i  (data_rdy_o),
    .dec_state_i (u_dec.state_q)
);

// File: sinc3_adc_tb.sv
//------------------------------
// Testbench for the sinc3 receiver
// Seeded bit stream, sinc3 reference model, word checks, timeout
//------------------------------
`include "sinc3_macros.svh"

module sinc3_adc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import sinc3_pkg::*;

    localparam int NUM_PHASES = 7;
    localparam int DIV        = `SINC_MCLK_DIV;
    localparam int FLUSH      = `SINC_FLUSH_WORDS;

    // DUT ports
    logic        word_clk;
    logic        reset_i;
    logic        mdata_i;
    dec_rate_e   rate_i;
    logic        mclkout_o;
    logic [15:0] data_o;
    logic        data_rdy_o;

    // Test phases, ones density counted out of 256
    dec_rate_e   ph_rate [NUM_PHASES];
    int unsigned ph_density [NUM_PHASES];
    int          ph_words [NUM_PHASES];

    // Model state
    int          seed = 25094;
    int          phase;
    int          bit_cnt;
    int          cur_r;
    logic        model_done;
    logic        mclk_prev;
    logic        bit_log [$];
    logic [15:0] exp_q [$];
    int          gap_q [$];

    // Checker state
    int          cycle_cnt;
    int          last_rdy_cycle;
    int          checked;
    int          timeout_cycles;
    logic [15:0] exp_word;
    int          exp_gap;

    sinc3_adc_top uut
    (
        .word_clk   (word_clk),
        .reset_i    (reset_i),
        .mdata_i    (mdata_i),
        .rate_i     (rate_i),
        .mclkout_o  (mclkout_o),
        .data_o     (data_o),
        .data_rdy_o (data_rdy_o)
    );

    //------------------------------
    // Helpers
    //------------------------------

    function automatic int ratio_of(input dec_rate_e rate);
        case (rate)
            RATE_64:  return 64;
            RATE_128: return 128;
            default:  return 256;
        endcase
    endfunction

    // Three cascaded length-r boxcars over the newest 3r logged bits
    function automatic logic [15:0] expected_word(input int r);
        int box1 [0:767];
        int box2 [0:767];
        int base;
        int s1;
        int s2;
        int s3;
        base = bit_log.size() - 3 * r;
        s1   = 0;
        s2   = 0;
        s3   = 0;
        for (int i = 0; i < 3 * r; i++)
        begin
            s1 += bit_log[base + i];
            if (i >= r)
            begin
                s1 -= bit_log[base + i - r];
            end
            box1[i] = s1;
        end
        // Second boxcar valid from index 2r-2
        for (int i = r - 1; i < 3 * r; i++)
        begin
            s2 += box1[i];
            if (i >= 2 * r - 1)
            begin
                s2 -= box1[i - r];
            end
            box2[i] = s2;
        end
        for (int i = 2 * r; i < 3 * r; i++)
        begin
            s3 += box2[i];
        end
        // Full scale r^3 brought to 2^16, then clipped
        s3 = s3 >> (3 * $clog2(r) - 16);
        return (s3 > 32'hFFFF) ? 16'hFFFF : 16'(s3);
    endfunction

    function automatic logic next_bit(input int unsigned density);
        logic [31:0] rnd;
        rnd = $random(seed);
        return (rnd[7:0] < density);
    endfunction

    task automatic set_phase(input int p, input dec_rate_e rate, input int unsigned density,
                             input int words);
        ph_rate[p]    = rate;
        ph_density[p] = density;
        ph_words[p]   = words;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on error");
    endtask

    //------------------------------
    // Clock, reset and phase table
    //------------------------------

    initial
    begin
        word_clk = 1'b0;
        forever #20 word_clk = ~word_clk;
    end

    initial
    begin
        // Neighbouring phases use different rates so each one restarts the DUT
        set_phase(0, RATE_256, 0, 2);
        set_phase(1, RATE_64, 256, 2);
        set_phase(2, RATE_256, 256, 2);
        set_phase(3, RATE_128, 256, 2);
        set_phase(4, RATE_256, 160, 24);
        set_phase(5, RATE_64, 60, 24);
        set_phase(6, RATE_128, 210, 24);
        timeout_cycles = 0;
        for (int p = 0; p < NUM_PHASES; p++)
        begin
            timeout_cycles += 2 * (ph_words[p] + FLUSH) * ratio_of(ph_rate[p]) * DIV;
        end
        phase          = 0;
        bit_cnt        = 0;
        cur_r          = ratio_of(ph_rate[0]);
        model_done     = 1'b0;
        mclk_prev      = 1'b0;
        cycle_cnt      = 0;
        last_rdy_cycle = 0;
        checked        = 0;
        reset_i        = 1'b1;
        mdata_i        = 1'b0;
        rate_i         = ph_rate[0];
        repeat (8) @(posedge word_clk);
        // Outputs idle while reset is held
        assert (!mclkout_o && !data_rdy_o && (data_o == 16'h0000))
            else abort_run($sformatf("ERR in reset mclkout_o 0x%h data_rdy_o 0x%h data_o 0x%h",
                                     mclkout_o, data_rdy_o, data_o));
        reset_i <= 1'b0;
    end

    //------------------------------
    // Stimulus and model
    //------------------------------

    always @(posedge word_clk)
    begin
        if (!reset_i && !model_done)
        begin
            mclk_prev <= mclkout_o;
            if (mclkout_o && !mclk_prev)
            begin
                // Phase start, the DUT takes this bit as bit 0 of the new rate
                if (bit_cnt == 0)
                begin
                    cur_r = ratio_of(ph_rate[phase]);
                    rate_i <= ph_rate[phase];
                    bit_log.delete();
                end
                // Bit held since the previous rising edge
                bit_log.push_back(mdata_i);
                bit_cnt++;
                if (((bit_cnt % cur_r) == 0) && ((bit_cnt / cur_r) > FLUSH))
                begin
                    exp_q.push_back(expected_word(cur_r));
                    if ((bit_cnt / cur_r) > FLUSH + 1)
                    begin
                        gap_q.push_back(cur_r * DIV);
                    end
                    else if (phase > 0)
                    begin
                        // Counted from the last word of the previous phase
                        gap_q.push_back((FLUSH + 1) * cur_r * DIV);
                    end
                    else
                    begin
                        gap_q.push_back(0);
                    end
                end
                if (bit_cnt == (ph_words[phase] + FLUSH) * cur_r)
                begin
                    phase++;
                    bit_cnt = 0;
                end
                if (phase == NUM_PHASES)
                begin
                    model_done = 1'b1;
                end
                else
                begin
                    // Next bit already follows the density of the phase it lands in
                    mdata_i <= next_bit(ph_density[phase]);
                end
            end
        end
    end

    //------------------------------
    // Word checks and timeout
    //------------------------------

    always @(posedge word_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            abort_run($sformatf("Timeout after %0d cycles with %0d words checked",
                                cycle_cnt, checked));
        end
        if (!reset_i && data_rdy_o)
        begin
            assert (exp_q.size() > 0)
                else abort_run("Output word arrived while none was expected");
            exp_word = exp_q.pop_front();
            exp_gap  = gap_q.pop_front();
            assert (data_o == exp_word)
                else abort_run($sformatf("ERR data_o 0x%h, expected 0x%h", data_o, exp_word));
            if (exp_gap != 0)
            begin
                assert ((cycle_cnt - last_rdy_cycle) == exp_gap)
                    else abort_run($sformatf("ERR data_rdy_o spacing 0x%h, expected 0x%h",
                                             cycle_cnt - last_rdy_cycle, exp_gap));
            end
            last_rdy_cycle = cycle_cnt;
            checked++;
        end
        if (model_done && (exp_q.size() == 0))
        begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: sinc3_adc_top.f
+incdir+.
sinc3_pkg.sv
sd_modulator_if.sv
sinc3_integrator.sv
sinc3_decimator.sv
sinc3_adc_top.sv
sinc3_adc_assert.sv
sinc3_adc_tb.sv

// File: sinc3_adc_top.sv
//------------------------------
// Sinc3 receiver top, modulator side, integrator, decimator
//------------------------------

module sinc3_adc_top
(
    input  logic                 word_clk,
    input  logic                 reset_i,
    input  logic                 mdata_i,
    input  sinc3_pkg::dec_rate_e rate_i,
    output logic                 mclkout_o,
    output logic [15:0]          data_o,
    output logic                 data_rdy_o
);
    import sinc3_pkg::*;

    //------------------------------
    // Internal nets
    //------------------------------

    // Synchronized modulator bit and its strobe
    logic bit_w;
    logic bit_stb_w;

    // Third integrator output, valid with acc_stb_w
    acc_t acc3_w;
    logic acc_stb_w;

    //------------------------------
    // Modulator side
    //------------------------------

    sd_modulator_if u_mod
    (
        .word_clk  (word_clk),
        .reset_i   (reset_i),
        .mdata_i   (mdata_i),
        .mclkout_o (mclkout_o),
        .bit_o     (bit_w),
        .bit_stb_o (bit_stb_w)
    );

    //------------------------------
    // Filter
    //------------------------------

    // Integrators at the bit rate
    sinc3_integrator u_int
    (
        .word_clk  (word_clk),
        .reset_i   (reset_i),
        .bit_i     (bit_w),
        .bit_stb_i (bit_stb_w),
        .acc3_o    (acc3_w),
        .acc_stb_o (acc_stb_w)
    );

    // Comb at the word rate
    sinc3_decimator u_dec
    (
        .word_clk   (word_clk),
        .reset_i    (reset_i),
        .acc3_i     (acc3_w),
        .acc_stb_i  (acc_stb_w),
        .rate_i     (rate_i),
        .data_o     (data_o),
        .data_rdy_o (data_rdy_o)
    );

endmodule

// File: sinc3_decimator.sv
//------------------------------
// Decimation counter, three-stage comb, warm-up FSM
// Output scaling, saturation and output register
//------------------------------
`include "sinc3_macros.svh"

module sinc3_decimator
(
    input  logic                 word_clk,
    input  logic                 reset_i,
    input  sinc3_pkg::acc_t      acc3_i,
    input  logic                 acc_stb_i,
    input  sinc3_pkg::dec_rate_e rate_i,
    output logic [15:0]          data_o,
    output logic                 data_rdy_o
);
    import sinc3_pkg::*;

    localparam int FLUSH_W = $clog2(`SINC_FLUSH_WORDS + 1);
    localparam int ACC_MSB = $bits(acc_t) - 1;

    // Rate in effect and its decode
    dec_rate_e          rate_q;
    logic [7:0]         last_idx;
    logic [3:0]         out_shift;

    // Decimation bookkeeping
    logic [7:0]         word_cnt_q;
    logic               rate_chg;
    logic               dec_pt;

    // Warm-up tracking
    dec_state_e         state_q;
    logic [FLUSH_W-1:0] flush_cnt_q;

    // Comb pipeline
    acc_t               acc3_d_q;
    acc_t               diff1_q;
    acc_t               diff1_d_q;
    acc_t               diff2_d_q;
    acc_t               diff2;
    acc_t               diff3;
    acc_t               scaled;
    logic               stage1_q;
    logic               emit1_q;

    //------------------------------
    // Rate decode
    //------------------------------

    always_comb
    begin
        case (rate_q)
            RATE_64:
            begin
                last_idx  = 8'd63;
                out_shift = 4'd2;
            end
            RATE_128:
            begin
                last_idx  = 8'd127;
                out_shift = 4'd5;
            end
            default:
            begin
                // RATE_256 and the unused code
                last_idx  = 8'd255;
                out_shift = 4'd8;
            end
        endcase
    end

    // A new rate is seen on a strobe and restarts everything
    assign rate_chg = acc_stb_i && (rate_i != rate_q);

    // Strobe carrying the last bit of an R-bit window
    assign dec_pt = acc_stb_i && !rate_chg && (word_cnt_q == last_idx);

    //------------------------------
    // Word counter
    //------------------------------

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            rate_q     <= RATE_64;
            word_cnt_q <= 8'd0;
        end
        else if (rate_chg)
        begin
            // The detecting strobe is bit 0 of the new rate
            rate_q     <= rate_i;
            word_cnt_q <= 8'd1;
        end
        else if (dec_pt)
        begin
            word_cnt_q <= 8'd0;
        end
        else if (acc_stb_i)
        begin
            word_cnt_q <= word_cnt_q + 8'd1;
        end
    end

    //------------------------------
    // Warm-up FSM
    //------------------------------

    // Comb delays hold stale data for the first words after a restart
    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q     <= ST_FLUSH;
            flush_cnt_q <= '0;
        end
        else if (rate_chg)
        begin
            state_q     <= ST_FLUSH;
            flush_cnt_q <= '0;
        end
        else if (dec_pt && (state_q == ST_FLUSH))
        begin
            if (flush_cnt_q == FLUSH_W'(`SINC_FLUSH_WORDS - 1))
            begin
                state_q     <= ST_RUN;
                flush_cnt_q <= '0;
            end
            else
            begin
                flush_cnt_q <= flush_cnt_q + FLUSH_W'(1);
            end
        end
    end

    //------------------------------
    // Comb and output
    //------------------------------

    // Second and third differences in the cycle after capture
    assign diff2 = diff1_q - diff1_d_q;
    assign diff3 = diff2 - diff2_d_q;

    // Full scale is R^3, brought down to 2^16 and clipped
    assign scaled = diff3 >> out_shift;

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            acc3_d_q   <= '0;
            diff1_q    <= '0;
            diff1_d_q  <= '0;
            diff2_d_q  <= '0;
            stage1_q   <= 1'b0;
            emit1_q    <= 1'b0;
            data_o     <= 16'h0000;
            data_rdy_o <= 1'b0;
        end
        else
        begin
            stage1_q   <= dec_pt;
            data_rdy_o <= stage1_q && emit1_q;
            if (rate_chg)
            begin
                // Delay line restarts from zero at the new rate
                acc3_d_q  <= '0;
                diff1_d_q <= '0;
                diff2_d_q <= '0;
            end
            else
            begin
                // Stage 1 captures the decimated integrator sum
                if (dec_pt)
                begin
                    diff1_q  <= acc3_i - acc3_d_q;
                    acc3_d_q <= acc3_i;
                    emit1_q  <= (state_q == ST_RUN);
                end
                // Stage 2 finishes the comb and loads the output
                if (stage1_q)
                begin
                    diff1_d_q <= diff1_q;
                    diff2_d_q <= diff2;
                    if (emit1_q)
                    begin
                        data_o <= (|scaled[ACC_MSB:16]) ? 16'hFFFF : scaled[15:0];
                    end
                end
            end
        end
    end

endmodule

// File: sinc3_integrator.sv
//------------------------------
// Three cascaded integrators at the modulator bit rate
//------------------------------
`include "sinc3_macros.svh"

module sinc3_integrator
(
    input  logic            word_clk,
    input  logic            reset_i,
    input  logic            bit_i,
    input  logic            bit_stb_i,
    output sinc3_pkg::acc_t acc3_o,
    output logic            acc_stb_o
);
    import sinc3_pkg::*;

    localparam int ACC_W = `SINC_ACC_W;

    // Input bit widened to the accumulator word
    logic [ACC_W-1:0] bit_ext;

    acc_t acc1_q;
    acc_t acc2_q;
    acc_t acc3_q;
    acc_t acc1_nxt;
    acc_t acc2_nxt;
    acc_t acc3_nxt;

    assign bit_ext = {{(ACC_W - 1){1'b0}}, bit_i};

    // Chained so acc3 includes the newest bit in the same update
    // Overflow wraps, the comb differences stay exact mod 2^ACC_W
    assign acc1_nxt = acc1_q + bit_ext;
    assign acc2_nxt = acc2_q + acc1_nxt;
    assign acc3_nxt = acc3_q + acc2_nxt;

    always_ff @(posedge word_clk or posedge reset_i)
    begin
        if (reset_i)
        begin
            acc1_q    <= '0;
            acc2_q    <= '0;
            acc3_q    <= '0;
            acc_stb_o <= 1'b0;
        end
        else
        begin
            // Strobe delayed to line up with the updated sum
            acc_stb_o <= bit_stb_i;
            if (bit_stb_i)
            begin
                acc1_q <= acc1_nxt;
                acc2_q <= acc2_nxt;
                acc3_q <= acc3_nxt;
            end
        end
    end

    assign acc3_o = acc3_q;

endmodule

// File: sinc3_macros.svh
//------------------------------
// Build-time constants for the sinc3 receiver
// Clock divider, accumulator width and warm-up word count
//------------------------------
`ifndef SINC3_MACROS_SVH
`define SINC3_MACROS_SVH

//------------------------------
// Modulator clock
//------------------------------

// word_clk cycles per modulator bit, must be even
`define SINC_MCLK_DIV 4

//------------------------------
// Filter datapath
//------------------------------

// Holds R^3 = 2^24 at ratio 256 without wrapping
`define SINC_ACC_W 25

// Words dropped while the comb delay line refills
`define SINC_FLUSH_WORDS 3

`endif

// File: sinc3_pkg.sv
//------------------------------
// Shared types of the sinc3 receiver
//------------------------------
`include "sinc3_macros.svh"

package sinc3_pkg;

    // Decimation ratio select
    // Output shift is 3*log2(R) - 16
    typedef enum logic [1:0]
    {
        RATE_64  = 2'd0,   // R=64, shift 2
        RATE_128 = 2'd1,   // R=128, shift 5
        RATE_256 = 2'd2    // R=256, shift 8
    } dec_rate_e;

    // Decimator output gating
    typedef enum logic
    {
        ST_FLUSH = 1'b0,
        ST_RUN   = 1'b1
    } dec_state_e;

    // Integrator and comb word, wraps modulo 2^ACC_W
    typedef logic [`SINC_ACC_W-1:0] acc_t;

endpackage
